/* rtl/merge_params.svh */
`ifndef MERGE_PARAMS_SVH
`define MERGE_PARAMS_SVH

// Width of one lane word and of the merged output
`define MERGE_DATA_W 32

// Width of the programmable start delay
`define MERGE_DELAY_W 32

`define MERGE_LANES 16 // Lanes serialized per pass

// Lane index width follows the lane count
`define MERGE_LANE_W $clog2(`MERGE_LANES)

`endif

/* rtl/mergePkg.sv */
`include "merge_params.svh"

package mergePkg;

    // One lane word, also the output word
    typedef logic [`MERGE_DATA_W-1:0] dataT;

    typedef logic [`MERGE_DELAY_W-1:0] delayT; // Start delay count

    // Index of the lane being merged
    typedef logic [`MERGE_LANE_W-1:0] laneT;

    // Pass sequence of the controller
    typedef enum logic [1:0] {
        Idle   = 2'd0,
        Wait   = 2'd1, // Start delay running
        Merge  = 2'd2, // One lane per cycle
        Finish = 2'd3  // Done pulse is issued from here
    } stateT;

endpackage

/* rtl/mergeIf.sv */
`timescale 1ns/1ps

interface mergeIf;

    logic load;      // Restart the delay and the lane index
    logic delayZero; // Start delay has expired
    logic step;      // Move on to the next lane
    mergePkg::laneT laneIdx;
    logic lastLane;
    logic emit;      // Register the current lane onto the output

    // Controller sequences the pass from the timer flags
    modport ctrlMp (
        output load,
        output step,
        output emit,
        input  delayZero,
        input  lastLane
    );

    modport timerMp (
        input  load,
        input  step,
        output delayZero,
        output laneIdx,
        output lastLane
    );

    // Selector only needs to know which lane and when
    modport selectMp (
        input laneIdx,
        input emit
    );

endinterface

/* rtl/mergeCtrl.sv */
`timescale 1ns/1ps

module mergeCtrl (
    input  logic   clk,
    input  logic   rst,
    input  logic   run,
    output logic   done,
    output logic   busy,
    mergeIf.ctrlMp bus
);

    mergePkg::stateT state;
    mergePkg::stateT stateNext;

    // A run strobe restarts the pass from any state
    always_comb begin
        stateNext = state;
        if (run) begin
            stateNext = mergePkg::Wait;
        end else begin
            case (state)
                mergePkg::Idle: begin
                    stateNext = mergePkg::Idle;
                end
                mergePkg::Wait: begin
                    if (bus.delayZero) begin
                        stateNext = mergePkg::Merge;
                    end
                end
                mergePkg::Merge: begin
                    if (bus.lastLane) begin
                        stateNext = mergePkg::Finish;
                    end
                end
                mergePkg::Finish: begin
                    stateNext = mergePkg::Idle;
                end
                default: begin
                    stateNext = mergePkg::Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mergePkg::Idle;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= stateNext;
            busy  <= (state == mergePkg::Wait) || (state == mergePkg::Merge); // Lags state by one edge
            done  <= (state == mergePkg::Finish);
        end
    end

    // The timer takes the new delay on the same edge that enters Wait
    assign bus.load = run;

    // A restart aborts the current lane instead of emitting it
    assign bus.emit = (state == mergePkg::Merge) && !run;
    assign bus.step = bus.emit;

    // Finish lasts one cycle, so the pulse can never stretch
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held high for two cycles");

    // Lanes may only be emitted once the timer has drained the start delay
    assert property (@(posedge clk) disable iff (rst)
        bus.emit |-> (state == mergePkg::Merge) && bus.delayZero)
        else $error("emit raised outside the merge window");

endmodule

/* rtl/mergeTimer.sv */
`timescale 1ns/1ps
`include "merge_params.svh"

module mergeTimer (
    input  logic            clk,
    input  logic            rst,
    input  mergePkg::delayT delay,
    mergeIf.timerMp         bus
);

    mergePkg::delayT delayCnt;
    mergePkg::laneT  laneIdx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            delayCnt <= '0;
            laneIdx  <= '0;
        end else if (bus.load) begin
            delayCnt <= delay; // Sampled with the run strobe
            laneIdx  <= '0;
        end else begin
            if (delayCnt != '0) begin
                delayCnt <= delayCnt - 1'b1;
            end
            if (bus.step) begin
                laneIdx <= laneIdx + 1'b1;
            end
        end
    end

    assign bus.delayZero = (delayCnt == '0);
    assign bus.laneIdx   = laneIdx;

    // High during the cycle that emits the final lane
    assign bus.lastLane = (laneIdx == mergePkg::laneT'(`MERGE_LANES - 1));

    // Stepping must wait for the start delay to run out
    assert property (@(posedge clk) disable iff (rst)
        (delayCnt != '0) && !bus.load |=> $stable(laneIdx))
        else $error("lane index moved while the start delay was running");

endmodule

/* rtl/mergeSelect.sv */
`timescale 1ns/1ps
`include "merge_params.svh"

module mergeSelect (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [`MERGE_LANES*`MERGE_DATA_W-1:0]  lanes,
    output mergePkg::dataT                         out,
    output logic                                   outValid,
    mergeIf.selectMp                               bus
);

    mergePkg::dataT laneWord;

    // Lane k sits in slice k of the flat bus
    assign laneWord = lanes[bus.laneIdx*`MERGE_DATA_W +: `MERGE_DATA_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out      <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= bus.emit;
            if (bus.emit) begin
                out <= laneWord; // Holds between passes
            end
        end
    end

    // One pass gives at most a full set of lanes back to back
    assert property (@(posedge clk) disable iff (rst)
        $rose(outValid) |-> ##[1:`MERGE_LANES] !outValid)
        else $error("outValid held beyond one pass of lanes");

endmodule

/* rtl/mergeTop.sv */
`timescale 1ns/1ps
`include "merge_params.svh"

module mergeTop (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   run,
    input  mergePkg::delayT                        delay,
    input  logic [`MERGE_LANES*`MERGE_DATA_W-1:0]  lanes,
    output mergePkg::dataT                         out,
    output logic                                   outValid,
    output logic                                   busy,
    output logic                                   done
);

    mergeIf bus ();

    // Pass sequencing and status
    mergeCtrl uCtrl (
        .clk  (clk),
        .rst  (rst),
        .run  (run),
        .done (done),
        .busy (busy),
        .bus  (bus.ctrlMp)
    );

    mergeTimer uTimer (
        .clk   (clk),
        .rst   (rst),
        .delay (delay),
        .bus   (bus.timerMp)
    );

    // Lane multiplexer and output registers
    mergeSelect uSelect (
        .clk      (clk),
        .rst      (rst),
        .lanes    (lanes),
        .out      (out),
        .outValid (outValid),
        .bus      (bus.selectMp)
    );

endmodule

/* verif/mergeTopTb.sv */
`timescale 1ns/1ps
`include "merge_params.svh"

module mergeTopTb;

    localparam int numTests  = 6;
    localparam int wordW     = `MERGE_DATA_W;
    localparam int laneCount = `MERGE_LANES;

    // One entry per pass with its start delay, restart flag and the edge of the second strobe
    int tblDelay     [numTests] = '{0, 1, 7, 3, 0, 2};
    bit tblRestart   [numTests] = '{0, 0, 0, 1, 1, 0};
    int tblRestartAt [numTests] = '{0, 0, 0, 11, 5, 0};

    logic                       clk;
    logic                       rst;
    logic                       run;
    mergePkg::delayT            delay;
    logic [laneCount*wordW-1:0] lanes;
    mergePkg::dataT             out;
    logic                       outValid;
    logic                       busy;
    logic                       done;

    logic [31:0]                lfsrState = 32'd52;
    logic [laneCount*wordW-1:0] lanesNow = '0;  // Driven at the latest rising edge
    logic [laneCount*wordW-1:0] lanesPrev = '0; // Sampled by the DUT at the latest edge
    mergePkg::dataT             lastOut = '0;

    int  edgeNum = 1000000; // Rising edges since the strobe was sampled
    int  passDelay = 0;
    int  validCount = 0;
    int  doneCount = 0;
    bit  passDone = 0;
    bit  busyExp = 0;
    int  checks = 0;
    int  errors = 0;
    int  cycleCount = 0;
    int  cycleLimit = 0;

    mergeTop UUT (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .delay    (delay),
        .lanes    (lanes),
        .out      (out),
        .outValid (outValid),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois step that shifts right and folds the taps back in on a one
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic mergePkg::dataT drawWord();
        mergePkg::dataT w;
        for (int i = 0; i < wordW; i++) begin
            w[i] = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
        return w;
    endfunction

    function automatic logic [laneCount*wordW-1:0] drawLanes();
        logic [laneCount*wordW-1:0] v;
        for (int k = 0; k < laneCount; k++) begin
            v[k*wordW +: wordW] = drawWord();
        end
        return v;
    endfunction

    function automatic int runLimit();
        int total;
        total = 50;
        for (int t = 0; t < numTests; t++) begin
            total += tblDelay[t] + 24;
        end
        return total;
    endfunction

    task automatic compareBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h at edge %0d", name, got, exp, edgeNum);
        end
    endtask

    task automatic compareWord(input string name, input mergePkg::dataT got,
                               input mergePkg::dataT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h at edge %0d", name, got, exp, edgeNum);
        end
    endtask

    // Expected outputs follow from the pass timing counted from the sampled strobe
    task automatic checkCycle();
        int lastValidEdge;
        int laneNum;
        logic validExp;
        logic doneExp;
        edgeNum++;
        lastValidEdge = passDelay + 2 + laneCount - 1;
        validExp = (edgeNum >= passDelay + 2) && (edgeNum <= lastValidEdge);
        doneExp = (edgeNum == lastValidEdge + 1);
        if (edgeNum != 0) begin
            busyExp = (edgeNum >= 1) && (edgeNum <= lastValidEdge); // Edge 0 keeps the old level
        end
        compareBit("outValid", outValid, validExp);
        compareBit("busy", busy, busyExp);
        checks++;
        if (done && !doneExp) begin
            errors++;
            $display("done pulsed at edge %0d of the pass, expected only at edge %0d",
                     edgeNum, lastValidEdge + 1);
        end else if (!done && doneExp) begin
            errors++;
            $display("done did not pulse at edge %0d of the pass", edgeNum);
        end
        if (done) begin
            doneCount++;
            passDone = 1;
        end
        if (validExp) begin
            laneNum = edgeNum - passDelay - 2;
            compareWord("out", out, lanesPrev[laneNum*wordW +: wordW]);
        end else if (!outValid) begin
            compareWord("out", out, lastOut); // Held between lanes and passes
        end
        if (outValid) begin
            validCount++;
            lastOut = out;
        end
        if (run) begin
            edgeNum = -1; // The coming edge samples the strobe
            passDelay = int'(delay);
            validCount = 0;
            doneCount = 0;
        end
    endtask

    task automatic runTest(input int t);
        int errorsBefore;
        errorsBefore = errors;
        passDone = 0;
        @(posedge clk);
        run <= 1'b1;
        delay <= mergePkg::delayT'(tblDelay[t]);
        @(posedge clk);
        run <= 1'b0;
        if (tblRestart[t]) begin
            repeat (tblRestartAt[t] - 1) @(posedge clk);
            run <= 1'b1;
            @(posedge clk);
            run <= 1'b0;
        end
        while (!passDone) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk); // Idle cycles are checked as well
        checks++;
        if (validCount != laneCount) begin
            errors++;
            $display("expected %0d valid output cycles, saw %0d", laneCount, validCount);
        end
        checks++;
        if (doneCount != 1) begin
            errors++;
            $display("expected one done pulse, saw %0d", doneCount);
        end
        if (errors == errorsBefore) begin
            $display("test %0d (delay %0d, restart %0d): passed", t, tblDelay[t], tblRestart[t]);
        end else begin
            $display("test %0d (delay %0d, restart %0d): failed with %0d errors",
                     t, tblDelay[t], tblRestart[t], errors - errorsBefore);
        end
    endtask

    // Fresh lane words every cycle so the sampling cycle matters
    always @(posedge clk) begin
        lanesPrev = lanesNow;
        lanesNow = drawLanes();
        lanes <= lanesNow;
    end

    always @(negedge clk) begin
        if (!rst) begin
            checkCycle();
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        cycleLimit = runLimit();
        rst = 1'b1;
        run = 1'b0;
        delay = '0;
        lanes = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("checks passed %0d, errors %0d", checks - errors, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* mergeTop.f */
+incdir+rtl
rtl/mergePkg.sv
rtl/mergeIf.sv
rtl/mergeCtrl.sv
rtl/mergeTimer.sv
rtl/mergeSelect.sv
rtl/mergeTop.sv
verif/mergeTopTb.sv

/* run.sh */
#!/bin/sh
# Builds the lane merger testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=mergeTopSim
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f mergeTop.f \
    --top-module mergeTopTb \
    -Mdir "$buildDir" \
    -o "$simName"
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

# The run passes only if the testbench printed its pass line
if grep -qx "Finished with no errors" "$logFile"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
